// ==== include/alu_params.svh ====
// -------------------------------------------------------------------------
// ALU pipe width definitions
// Data path, commit id, register address and shift amount widths shared
// by the execute pipe and its testbench
// -------------------------------------------------------------------------

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// -------------------------------------------------------------------------
// Data path
// -------------------------------------------------------------------------
`define ALU_XLEN 32        // RV32 integer word

// Shift amount covers the full word, log2(ALU_XLEN)
`define ALU_SHAMT_W 5

// -------------------------------------------------------------------------
// Tags
// -------------------------------------------------------------------------
`define ALU_CMT_ID_W 6     // Commit id carried to the done report

// x0..x31
`define ALU_REG_ADDR_W 5

`endif

// ==== rtl/alu_pkg.sv ====
// -------------------------------------------------------------------------
// ALU pipe types
// Operation codes, immediate kinds and the payloads of the two
// execute stages
// -------------------------------------------------------------------------

`include "alu_params.svh"

package alu_pkg;

  // -----------------------------------------------------------------------
  // Basic words
  // -----------------------------------------------------------------------
  typedef logic [`ALU_XLEN-1:0]       xlen_t;
  typedef logic [`ALU_CMT_ID_W-1:0]   cmt_id_t;
  typedef logic [`ALU_REG_ADDR_W-1:0] reg_addr_t;

  // Integer operations kept in this pipe
  typedef enum logic [3:0] {
    OP_ADD     = 4'd0,
    OP_SUB     = 4'd1,
    OP_SLL     = 4'd2,
    OP_SLT     = 4'd3,
    OP_SLTU    = 4'd4,
    OP_XOR     = 4'd5,
    OP_SRL     = 4'd6,
    OP_SRA     = 4'd7,
    OP_OR      = 4'd8,
    OP_AND     = 4'd9,
    OP_LUI     = 4'd10,
    OP_AUIPC   = 4'd11,
    OP_ILLEGAL = 4'd15   // Result forced to zero
  } alu_op_t;

  // Source of operand b
  typedef enum logic [1:0] {
    IMM_NONE = 2'd0,     // Second register
    IMM_I    = 2'd1,     // Sign-extended I immediate
    IMM_SH   = 2'd2,     // Zero-extended shift amount
    IMM_U    = 2'd3      // Upper immediate, low 12 bits zero
  } imm_sel_t;

  // -----------------------------------------------------------------------
  // Stage payloads
  // -----------------------------------------------------------------------
  typedef struct packed {
    alu_op_t   op;
    xlen_t     opa;
    xlen_t     opb;
    xlen_t     pc;
    cmt_id_t   cmt_id;
    reg_addr_t rd;
    logic      wr_en;
  } ex1_payload_t;

  typedef struct packed {
    xlen_t     result;
    cmt_id_t   cmt_id;
    reg_addr_t rd;
    logic      wr_en;
  } ex2_payload_t;

endpackage

// ==== rtl/alu_decode.sv ====
// -------------------------------------------------------------------------
// ALU instruction decode
// Maps OP, OP-IMM, LUI and AUIPC onto an ALU operation and selects the
// two operands for the first execute stage
// -------------------------------------------------------------------------

`include "alu_params.svh"

module alu_decode (
  input  logic                  i_issue_valid,
  input  logic [31:0]           i_inst,
  input  alu_pkg::xlen_t        i_pc,
  input  alu_pkg::xlen_t        i_rs1_data,
  input  alu_pkg::xlen_t        i_rs2_data,
  input  alu_pkg::cmt_id_t      i_cmt_id,
  output logic                  o_valid,
  output alu_pkg::ex1_payload_t o_payload
);

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB / SRA

  logic [6:0]         w_opcode;
  logic [2:0]         w_funct3;
  logic [6:0]         w_funct7;
  alu_pkg::reg_addr_t w_rd;
  alu_pkg::alu_op_t   w_op;
  alu_pkg::imm_sel_t  w_imm_sel;
  alu_pkg::xlen_t     w_imm_i;
  alu_pkg::xlen_t     w_imm_sh;
  alu_pkg::xlen_t     w_imm_u;
  alu_pkg::xlen_t     w_opb;

  assign w_opcode = i_inst[6:0];
  assign w_rd     = i_inst[11:7];
  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  // Immediate candidates
  assign w_imm_i  = {{(`ALU_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign w_imm_sh = {{(`ALU_XLEN-`ALU_SHAMT_W){1'b0}}, i_inst[20 +: `ALU_SHAMT_W]};
  assign w_imm_u  = {i_inst[31:12], 12'h000};

  // -----------------------------------------------------------------------
  // Operation decode
  // -----------------------------------------------------------------------
  always_comb begin
    w_op      = alu_pkg::OP_ILLEGAL;
    w_imm_sel = alu_pkg::IMM_NONE;
    case (w_opcode)
      OPC_OP: begin
        case ({w_funct7, w_funct3})
          {F7_BASE, 3'b000}: w_op = alu_pkg::OP_ADD;
          {F7_ALT,  3'b000}: w_op = alu_pkg::OP_SUB;
          {F7_BASE, 3'b001}: w_op = alu_pkg::OP_SLL;
          {F7_BASE, 3'b010}: w_op = alu_pkg::OP_SLT;
          {F7_BASE, 3'b011}: w_op = alu_pkg::OP_SLTU;
          {F7_BASE, 3'b100}: w_op = alu_pkg::OP_XOR;
          {F7_BASE, 3'b101}: w_op = alu_pkg::OP_SRL;
          {F7_ALT,  3'b101}: w_op = alu_pkg::OP_SRA;
          {F7_BASE, 3'b110}: w_op = alu_pkg::OP_OR;
          {F7_BASE, 3'b111}: w_op = alu_pkg::OP_AND;
          default:           w_op = alu_pkg::OP_ILLEGAL;  // M extension etc.
        endcase
      end
      OPC_OP_IMM: begin
        w_imm_sel = alu_pkg::IMM_I;
        case (w_funct3)
          3'b000: w_op = alu_pkg::OP_ADD;
          3'b010: w_op = alu_pkg::OP_SLT;
          3'b011: w_op = alu_pkg::OP_SLTU;
          3'b100: w_op = alu_pkg::OP_XOR;
          3'b110: w_op = alu_pkg::OP_OR;
          3'b111: w_op = alu_pkg::OP_AND;
          3'b001: begin
            w_imm_sel = alu_pkg::IMM_SH;
            if (w_funct7 == F7_BASE) w_op = alu_pkg::OP_SLL;
          end
          default: begin  // 3'b101, SRLI / SRAI
            w_imm_sel = alu_pkg::IMM_SH;
            if (w_funct7 == F7_BASE)     w_op = alu_pkg::OP_SRL;
            else if (w_funct7 == F7_ALT) w_op = alu_pkg::OP_SRA;
          end
        endcase
      end
      OPC_LUI: begin
        w_op      = alu_pkg::OP_LUI;
        w_imm_sel = alu_pkg::IMM_U;
      end
      OPC_AUIPC: begin
        w_op      = alu_pkg::OP_AUIPC;
        w_imm_sel = alu_pkg::IMM_U;
      end
      default: ;
    endcase
  end

  // Immediate replaces the second register
  always_comb begin
    case (w_imm_sel)
      alu_pkg::IMM_I:  w_opb = w_imm_i;
      alu_pkg::IMM_SH: w_opb = w_imm_sh;
      alu_pkg::IMM_U:  w_opb = w_imm_u;
      default:         w_opb = i_rs2_data;
    endcase
  end

  // -----------------------------------------------------------------------
  // Stage-one payload
  // -----------------------------------------------------------------------
  always_comb begin
    o_payload.op     = w_op;
    o_payload.opa    = (w_op == alu_pkg::OP_AUIPC) ? i_pc : i_rs1_data;
    o_payload.opb    = w_opb;
    o_payload.pc     = i_pc;
    o_payload.cmt_id = i_cmt_id;
    o_payload.rd     = w_rd;
    // No register write for x0 or an undecoded instruction
    o_payload.wr_en  = (w_rd != '0) && (w_op != alu_pkg::OP_ILLEGAL);
  end

  assign o_valid = i_issue_valid;

endmodule

// ==== rtl/alu_stage_reg.sv ====
// -------------------------------------------------------------------------
// Flushable pipeline stage register
// Holds one payload and its valid bit; a flush in the load cycle
// drops the incoming entry
// -------------------------------------------------------------------------

module alu_stage_reg #(
  parameter type PAYLOAD_T = logic [31:0]
) (
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  logic     i_flush,
  input  logic     i_valid,
  input  PAYLOAD_T i_payload,
  output logic     o_valid,
  output PAYLOAD_T o_payload
);

  // Valid bit
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & ~i_flush;  // Killed entry never shows
    end
  end

  // Payload, loaded every cycle
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_payload <= '0;
    end else begin
      o_payload <= i_payload;
    end
  end

endmodule

// ==== rtl/alu_execute.sv ====
// -------------------------------------------------------------------------
// ALU execute
// Integer result for the decoded operation, packed into the
// stage-two payload for write-back and done report
// -------------------------------------------------------------------------

`include "alu_params.svh"

module alu_execute (
  input  logic                  i_valid,
  input  alu_pkg::ex1_payload_t i_payload,
  output logic                  o_valid,
  output alu_pkg::ex2_payload_t o_payload
);

  alu_pkg::xlen_t           w_opa;
  alu_pkg::xlen_t           w_opb;
  logic [`ALU_SHAMT_W-1:0]  w_shamt;
  alu_pkg::xlen_t           w_sra;
  logic                     w_lt_signed;
  logic                     w_lt_unsigned;
  alu_pkg::xlen_t           w_result;

  assign w_opa   = i_payload.opa;
  assign w_opb   = i_payload.opb;
  assign w_shamt = w_opb[`ALU_SHAMT_W-1:0];  // Upper bits of b ignored

  // Arithmetic right shift kept apart so the sign survives
  assign w_sra = $signed(w_opa) >>> w_shamt;

  // Comparisons
  assign w_lt_signed   = $signed(w_opa) < $signed(w_opb);
  assign w_lt_unsigned = w_opa < w_opb;

  // -----------------------------------------------------------------------
  // Result select
  // -----------------------------------------------------------------------
  always_comb begin
    case (i_payload.op)
      alu_pkg::OP_ADD:   w_result = w_opa + w_opb;
      alu_pkg::OP_SUB:   w_result = w_opa - w_opb;
      alu_pkg::OP_SLL:   w_result = w_opa << w_shamt;
      alu_pkg::OP_SRL:   w_result = w_opa >> w_shamt;
      alu_pkg::OP_SRA:   w_result = w_sra;
      alu_pkg::OP_SLT:   w_result = {{(`ALU_XLEN-1){1'b0}}, w_lt_signed};
      alu_pkg::OP_SLTU:  w_result = {{(`ALU_XLEN-1){1'b0}}, w_lt_unsigned};
      alu_pkg::OP_XOR:   w_result = w_opa ^ w_opb;
      alu_pkg::OP_OR:    w_result = w_opa | w_opb;
      alu_pkg::OP_AND:   w_result = w_opa & w_opb;
      alu_pkg::OP_LUI:   w_result = w_opb;          // Upper immediate as is
      alu_pkg::OP_AUIPC: w_result = w_opa + w_opb;  // a holds the pc
      default:           w_result = '0;             // Illegal
    endcase
  end

  // -----------------------------------------------------------------------
  // Stage-two payload
  // -----------------------------------------------------------------------
  always_comb begin
    o_payload.result = w_result;
    o_payload.cmt_id = i_payload.cmt_id;
    o_payload.rd     = i_payload.rd;
    o_payload.wr_en  = i_payload.wr_en;
  end

  assign o_valid = i_valid;

endmodule

// ==== rtl/alu_pipe.sv ====
// -------------------------------------------------------------------------
// Two-stage integer execute pipe
// Decode and operand select, stage register, ALU, stage register;
// drives the register write port and the done report
// -------------------------------------------------------------------------

module alu_pipe (
  input  logic               i_clk,
  input  logic               i_reset_n,

  // Issue
  input  logic               i_issue_valid,
  input  logic [31:0]        i_inst,
  input  alu_pkg::xlen_t     i_pc,
  input  alu_pkg::xlen_t     i_rs1_data,
  input  alu_pkg::xlen_t     i_rs2_data,
  input  alu_pkg::cmt_id_t   i_cmt_id,
  input  logic               i_flush,

  // Register write port
  output logic               o_wr_valid,
  output alu_pkg::reg_addr_t o_wr_rd,
  output alu_pkg::xlen_t     o_wr_data,

  // Done report
  output logic               o_done_valid,
  output alu_pkg::cmt_id_t   o_done_cmt_id
);

  logic                  w_dec_valid;
  alu_pkg::ex1_payload_t w_dec_payload;
  logic                  w_ex1_valid;
  alu_pkg::ex1_payload_t w_ex1_payload;
  logic                  w_exe_valid;
  alu_pkg::ex2_payload_t w_exe_payload;
  logic                  w_ex2_valid;
  alu_pkg::ex2_payload_t w_ex2_payload;

  // -----------------------------------------------------------------------
  // EX0 decode, EX1 register
  // -----------------------------------------------------------------------
  alu_decode u_decode (
    .i_issue_valid (i_issue_valid),
    .i_inst        (i_inst),
    .i_pc          (i_pc),
    .i_rs1_data    (i_rs1_data),
    .i_rs2_data    (i_rs2_data),
    .i_cmt_id      (i_cmt_id),
    .o_valid       (w_dec_valid),
    .o_payload     (w_dec_payload)
  );

  alu_stage_reg #(
    .PAYLOAD_T (alu_pkg::ex1_payload_t)
  ) u_ex1_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),        // Kills the issuing instruction
    .i_valid   (w_dec_valid),
    .i_payload (w_dec_payload),
    .o_valid   (w_ex1_valid),
    .o_payload (w_ex1_payload)
  );

  // -----------------------------------------------------------------------
  // EX1 execute, EX2 register
  // -----------------------------------------------------------------------
  alu_execute u_execute (
    .i_valid   (w_ex1_valid),
    .i_payload (w_ex1_payload),
    .o_valid   (w_exe_valid),
    .o_payload (w_exe_payload)
  );

  alu_stage_reg #(
    .PAYLOAD_T (alu_pkg::ex2_payload_t)
  ) u_ex2_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),        // Kills the middle-stage instruction
    .i_valid   (w_exe_valid),
    .i_payload (w_exe_payload),
    .o_valid   (w_ex2_valid),
    .o_payload (w_ex2_payload)
  );

  // Write-back and done report
  assign o_wr_valid    = w_ex2_valid & w_ex2_payload.wr_en;
  assign o_wr_rd       = w_ex2_payload.rd;
  assign o_wr_data     = w_ex2_payload.result;
  assign o_done_valid  = w_ex2_valid;
  assign o_done_cmt_id = w_ex2_payload.cmt_id;

endmodule

// ==== sim/tb_clock_gen.sv ====
// ---------------------------------------------------------------------------
// Testbench clock and reset
// 100 ns clock, active-low reset held for the first four cycles
// ---------------------------------------------------------------------------

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;  // Released on a rising edge
  end

endmodule

// ==== sim/tb_alu_pipe.sv ====
// ---------------------------------------------------------------------------
// ALU pipe testbench
// Random and directed issue, a two-deep reference delay line and
// concurrent assertions on the write port and done report
// ---------------------------------------------------------------------------

`include "alu_params.svh"

module tb_alu_pipe;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RR_ROUNDS   = 4;   // Ten register-register kinds per round
  localparam int IMM_RANDOM  = 24;
  localparam int UPPER_COUNT = 8;
  localparam int DIRECTED    = 22;
  localparam int N_TESTS     = RR_ROUNDS * 10 + IMM_RANDOM + UPPER_COUNT + DIRECTED;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  logic               clk;
  logic               reset_n;
  logic               issue_valid;
  logic [31:0]        inst;
  alu_pkg::xlen_t     pc;
  alu_pkg::xlen_t     rs1_data;
  alu_pkg::xlen_t     rs2_data;
  alu_pkg::cmt_id_t   cmt_id;
  logic               flush;
  logic               o_wr_valid;
  alu_pkg::reg_addr_t o_wr_rd;
  alu_pkg::xlen_t     o_wr_data;
  logic               o_done_valid;
  alu_pkg::cmt_id_t   o_done_cmt_id;

  // Reference delay line with one entry per stage
  logic               s1_valid, s2_valid;
  logic               s1_wr, s2_wr;
  alu_pkg::xlen_t     s1_result, s2_result;
  alu_pkg::reg_addr_t s1_rd, s2_rd;
  alu_pkg::cmt_id_t   s1_cmt, s2_cmt;

  int valid_errors = 0;
  int tag_errors   = 0;
  int data_errors  = 0;

  tb_clock_gen u_clock_gen (.o_clk(clk), .o_reset_n(reset_n));

  alu_pipe i_dut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_issue_valid (issue_valid),
    .i_inst        (inst),
    .i_pc          (pc),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .i_cmt_id      (cmt_id),
    .i_flush       (flush),
    .o_wr_valid    (o_wr_valid),
    .o_wr_rd       (o_wr_rd),
    .o_wr_data     (o_wr_data),
    .o_done_valid  (o_done_valid),
    .o_done_cmt_id (o_done_cmt_id)
  );

  // ---------------------------------------------------------------------------
  // Reference model from the RV32I rules
  // ---------------------------------------------------------------------------
  function automatic logic ref_legal(input logic [31:0] ins);
    case (ins[6:0])
      OPC_OP:
        return (ins[31:25] == 7'h00) ||
               (ins[31:25] == 7'h20 && (ins[14:12] == 3'd0 || ins[14:12] == 3'd5));
      OPC_OP_IMM: begin
        if (ins[14:12] == 3'd1) return ins[31:25] == 7'h00;
        if (ins[14:12] == 3'd5) return ins[31:25] == 7'h00 || ins[31:25] == 7'h20;
        return 1'b1;
      end
      OPC_LUI, OPC_AUIPC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic alu_pkg::xlen_t ref_result(input logic [31:0] ins,
      input alu_pkg::xlen_t pc_v, input alu_pkg::xlen_t a, input alu_pkg::xlen_t b);
    alu_pkg::xlen_t upper;
    alu_pkg::xlen_t opnd;
    logic [4:0]     sh;
    logic           alt;
    upper = {ins[31:12], 12'h000};
    if (!ref_legal(ins)) return '0;
    if (ins[6:0] == OPC_LUI) return upper;
    if (ins[6:0] == OPC_AUIPC) return pc_v + upper;
    // Bit 5 of the opcode tells OP from OP-IMM
    opnd = ins[5] ? b : {{20{ins[31]}}, ins[31:20]};
    sh   = opnd[4:0];
    alt  = ins[30] && (ins[5] || ins[14:12] == 3'd5);  // SUB, SRA, SRAI
    case (ins[14:12])
      3'd0: return alt ? a - opnd : a + opnd;
      3'd1: return a << sh;
      3'd2: return {31'd0, $signed(a) < $signed(opnd)};
      3'd3: return {31'd0, a < opnd};
      3'd4: return a ^ opnd;
      3'd5: return (alt && a[31]) ? ~(~a >> sh) : a >> sh;
      3'd6: return a | opnd;
      default: return a & opnd;
    endcase
  endfunction

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid & ~flush;
      s1_result <= ref_result(inst, pc, rs1_data, rs2_data);
      s1_rd     <= inst[11:7];
      s1_wr     <= (inst[11:7] != 5'd0) && ref_legal(inst);
      s1_cmt    <= cmt_id;
      s2_valid  <= s1_valid & ~flush;  // Flush also kills the middle stage
      s2_result <= s1_result;
      s2_rd     <= s1_rd;
      s2_wr     <= s1_wr;
      s2_cmt    <= s1_cmt;
    end
  end

  // ---------------------------------------------------------------------------
  // Output checks on the falling edge
  // ---------------------------------------------------------------------------
  a_done_valid: assert property (@(negedge clk) disable iff (!reset_n)
      o_done_valid == s2_valid)
    else begin
      valid_errors++;
      $display("** Error at %0t: o_done_valid expected %b, actual %b",
               $time, s2_valid, o_done_valid);
    end

  a_wr_valid: assert property (@(negedge clk) disable iff (!reset_n)
      o_wr_valid == (s2_valid && s2_wr))
    else begin
      valid_errors++;
      $display("** Error at %0t: o_wr_valid expected %b, actual %b",
               $time, s2_valid && s2_wr, o_wr_valid);
    end

  a_cmt_id: assert property (@(negedge clk) disable iff (!reset_n)
      !s2_valid || o_done_cmt_id == s2_cmt)
    else begin
      tag_errors++;
      $display("** Error at %0t: o_done_cmt_id expected %h, actual %h",
               $time, s2_cmt, o_done_cmt_id);
    end

  a_wr_rd: assert property (@(negedge clk) disable iff (!reset_n)
      !s2_valid || o_wr_rd == s2_rd)
    else begin
      tag_errors++;
      $display("** Error at %0t: o_wr_rd expected %0d, actual %0d", $time, s2_rd, o_wr_rd);
    end

  a_wr_data: assert property (@(negedge clk) disable iff (!reset_n)
      !s2_valid || o_wr_data == s2_result)
    else begin
      data_errors++;
      $display("** Error at %0t: o_wr_data expected %h, actual %h",
               $time, s2_result, o_wr_data);
    end

  // ---------------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd);
    logic [31:0] r;
    r = $urandom;
    return {f7, r[24:20], r[19:15], f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd);
    logic [31:0] r;
    r = $urandom;
    return {imm, r[19:15], f3, rd, OPC_OP_IMM};
  endfunction

  // Ten register-register kinds in funct3 order with SUB and SRA in between
  function automatic logic [31:0] rr_inst(input int kind, input logic [4:0] rd);
    case (kind)
      0: return enc_r(7'h00, 3'd0, rd);
      1: return enc_r(7'h20, 3'd0, rd);
      2: return enc_r(7'h00, 3'd1, rd);
      3: return enc_r(7'h00, 3'd2, rd);
      4: return enc_r(7'h00, 3'd3, rd);
      5: return enc_r(7'h00, 3'd4, rd);
      6: return enc_r(7'h00, 3'd5, rd);
      7: return enc_r(7'h20, 3'd5, rd);
      8: return enc_r(7'h00, 3'd6, rd);
      default: return enc_r(7'h00, 3'd7, rd);
    endcase
  endfunction

  task automatic drive_slot(input logic v, input logic [31:0] ins, input alu_pkg::xlen_t a,
                            input alu_pkg::xlen_t b, input logic fl);
    logic [31:0] r_pc;
    logic [31:0] r_tag;
    r_pc  = $urandom;
    r_tag = $urandom;
    @(posedge clk);
    issue_valid <= v;
    inst        <= ins;
    pc          <= {r_pc[31:2], 2'b00};
    rs1_data    <= a;
    rs2_data    <= b;
    cmt_id      <= r_tag[`ALU_CMT_ID_W-1:0];
    flush       <= fl;
  endtask

  task automatic issue(input logic [31:0] ins, input alu_pkg::xlen_t a);
    drive_slot(1'b1, ins, a, $urandom, 1'b0);
  endtask

  task automatic idle(input logic fl);
    drive_slot(1'b0, 32'h0000_0013, '0, '0, fl);
  endtask

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [11:0] imm;
    r           = $urandom(32'hff2ac1b8);  // Seed once
    issue_valid = 1'b0;
    inst        = '0;
    pc          = '0;
    rs1_data    = '0;
    rs2_data    = '0;
    cmt_id      = '0;
    flush       = 1'b0;
    @(posedge reset_n);
    repeat (3) idle(1'b0);  // Quiet pipe after reset

    // Back-to-back issue keeps two in flight
    for (int round = 0; round < RR_ROUNDS; round++) begin
      for (int kind = 0; kind < 10; kind++) begin
        r = $urandom;
        drive_slot(1'b1, rr_inst(kind, r[4:0]), $urandom, $urandom, 1'b0);
      end
    end

    // Negative immediates and arithmetic shifts come first
    issue(enc_i(12'hfff, 3'd0, 5'd1), $urandom);
    issue(enc_i(12'h800, 3'd0, 5'd2), $urandom);
    issue(enc_i({7'h20, 5'd31}, 3'd5, 5'd3), 32'h8000_1234);
    issue(enc_i({7'h20, 5'd7}, 3'd5, 5'd4), 32'hf0f0_0f0f);
    issue(enc_i({7'h00, 5'd4}, 3'd5, 5'd5), 32'hf0f0_0f0f);
    issue(enc_i(12'hffb, 3'd2, 5'd6), 32'hffff_fff0);
    issue(enc_i(12'hfff, 3'd3, 5'd7), $urandom);
    for (int i = 0; i < IMM_RANDOM; i++) begin
      r = $urandom;
      if (r[2:0] == 3'd1)      imm = {7'h00, r[12:8]};
      else if (r[2:0] == 3'd5) imm = {(r[3] ? 7'h20 : 7'h00), r[12:8]};
      else                     imm = r[31:20];
      issue(enc_i(imm, r[2:0], r[17:13]), $urandom);
    end

    // LUI and AUIPC alternate
    for (int i = 0; i < UPPER_COUNT; i++) begin
      r = $urandom;
      issue({r[31:12], r[11:7], (i[0] ? OPC_AUIPC : OPC_LUI)}, $urandom);
    end

    // Flush kills the issuing and middle instructions only
    idle(1'b0);
    issue(rr_inst(0, 5'd10), $urandom);
    issue(rr_inst(5, 5'd11), $urandom);
    drive_slot(1'b1, rr_inst(8, 5'd12), $urandom, $urandom, 1'b1);
    idle(1'b0);
    issue(rr_inst(1, 5'd13), $urandom);
    idle(1'b1);                          // Catches it in the middle stage

    // Done without a register write
    issue(rr_inst(0, 5'd0), $urandom);
    r = $urandom;
    issue({r[31:12], 5'd9, 7'b0000011}, $urandom);  // Load opcode
    issue(enc_r(7'h01, 3'd0, 5'd8), $urandom);     // MUL
    issue(enc_i({7'h20, 5'd3}, 3'd1, 5'd4), $urandom);

    idle(1'b0);
    while (s1_valid || s2_valid) @(negedge clk);
    @(posedge clk);

    $display("Error counts: valid %0d, tag %0d, data %0d",
             valid_errors, tag_errors, data_errors);
    if (valid_errors + tag_errors + data_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((N_TESTS + 20) * 100);
    $display("Timeout: run did not finish within %0d ns", (N_TESTS + 20) * 100);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
rtl/alu_pkg.sv
rtl/alu_decode.sv
rtl/alu_stage_reg.sv
rtl/alu_execute.sv
rtl/alu_pipe.sv
sim/tb_clock_gen.sv
sim/tb_alu_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ALU pipe testbench with Verilator.
# Exit status is zero only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f src.f --top-module tb_alu_pipe \
  && ./obj_dir/Vtb_alu_pipe | tee /dev/stderr | grep -q "Simulation PASSED" \
  && { echo "run_sim: pass"; exit 0; } \
  || { echo "run_sim: fail"; exit 1; }
